/* tb.f */
design/ldpcPkg.sv
design/ldpcRegBus.sv
design/wbSlave.sv
design/ldpcRegs.sv
design/frameSync.sv
design/llrScaler.sv
design/outputPacer.sv
design/ldpcFrontEnd.sv
sim/ldpcFrontEndTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= ldpcFrontEndTb
FILELIST  ?= tb.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJDIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf $(OBJDIR)

/* sim/ldpcFrontEndTb.sv */
`timescale 1ns/100ps

module ldpcFrontEndTb;

    localparam int frameLen   = (1024 * 5 / 4 + 64) / 2;  // 672 symbols per frame.
    localparam int dataLen    = frameLen - ldpcPkg::markerSymbols;
    localparam int ackTimeout = 20;

    logic        busClk = 1'b0;
    logic        arstN;
    logic        wbCyc, wbStb, wbWe;
    logic [12:0] wbAdr;
    logic [3:0]  wbSel;
    logic [31:0] wbDatWr;
    logic [31:0] wbDatRd;
    logic        wbAck;
    logic        sampleValid;
    logic signed [ldpcPkg::sampleWidth-1:0] sampleI, sampleQ;
    logic        llrValid;
    logic signed [ldpcPkg::llrWidth-1:0]    llrI, llrQ;
    logic        outputEn;
    logic        inSync;

    logic [15:0] lfsr = 16'd16280;
    logic [31:0] image [3];  // Host view of ctrl, inverse mean and divider.
    int          cycleCount = 0;
    int          ackCycle;
    int          checkCount = 0;
    int          errorCount = 0;
    int          failCount = 0;
    logic signed [5:0] wantI [$];
    logic signed [5:0] wantQ [$];
    int          dueCycle [$];
    int          pulseCycles [$];

    ldpcFrontEnd uut (.*);

    always #50 busClk = ~busClk;

    always @(posedge busClk) cycleCount <= cycleCount + 1;

    //////////////////////////////////////////////////
    // Random numbers and reference model
    //////////////////////////////////////////////////
    // Galois form, taps 16, 14, 13 and 11.
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsrNext(lfsr);
        end
        return v;
    endfunction

    function automatic logic [31:0] fieldMask(input logic [12:0] adr);
        case (adr)
            ldpcPkg::ctrlReg:         return 32'h87FF_000B;
            ldpcPkg::inverseMeanReg:  return 32'h0007_FFFF;
            ldpcPkg::outputClkDivReg: return 32'h0000_FFFF;
            default:                  return 32'h0;
        endcase
    endfunction

    function automatic logic [31:0] laneMerge(input logic [31:0] old, input logic [31:0] data,
                                             input logic [3:0] sel, input logic [31:0] mask);
        logic [31:0] v;
        v = old;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                v[8*b +: 8] = data[8*b +: 8];
            end
        end
        return v & mask;
    endfunction

    function automatic logic [31:0] refReadback(input logic [12:0] adr);
        if (fieldMask(adr) == 32'h0) begin
            return 32'h0;
        end
        return image[adr[3:2]];
    endfunction

    function automatic logic [31:0] refStatus(input logic sync, input ldpcPkg::syncState st,
                                              input logic [1:0] rot);
        return {sync, 21'h0, rot, 6'h0, st};
    endfunction

    // Product shifted right by 15 minus the exponent, clamped to -32..31.
    function automatic logic signed [5:0] refLlr(input logic signed [7:0] s,
                                                 input logic [15:0] mant, input logic [2:0] expo);
        int p;
        p = int'(s) * int'(mant);
        p = p >>> (15 - int'(expo));
        if (p > 31) begin
            p = 31;
        end else if (p < -32) begin
            p = -32;
        end
        return 6'(p);
    endfunction

    function automatic int refPulseInterval(input logic [15:0] div);
        return int'(div) + 1;
    endfunction

    //////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////
    task automatic checkWord(input string name, input logic [31:0] got, input logic [31:0] want);
        checkCount++;
        if (got !== want) begin
            $display("** Error: %s is 0x%h, expected 0x%h", name, got, want);
            errorCount++;
        end
    endtask

    task automatic checkLlr(input string name, input logic signed [5:0] got,
                            input logic signed [5:0] want);
        checkCount++;
        if (got !== want) begin
            $display("** Error: %s is 0x%h, expected 0x%h", name, got, want);
            errorCount++;
        end
    endtask

    task automatic checkState(input string name, input ldpcPkg::syncState got,
                              input ldpcPkg::syncState want);
        checkCount++;
        if (got !== want) begin
            $display("** Error: %s is 0x%h, expected 0x%h", name, got, want);
            errorCount++;
        end
    endtask

    task automatic checkRotation(input string name, input logic [1:0] got, input logic [1:0] want);
        checkCount++;
        if (got !== want) begin
            $display("** Error: %s is 0x%h, expected 0x%h", name, got, want);
            errorCount++;
        end
    endtask

    task automatic checkInterval(input string name, input int got, input int want);
        checkCount++;
        if (got != want) begin
            $display("** Error: %s is 0x%h, expected 0x%h", name, got, want);
            errorCount++;
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic want);
        checkCount++;
        if (got !== want) begin
            $display("** Error: %s is 0x%h, expected 0x%h", name, got, want);
            errorCount++;
        end
    endtask

    //////////////////////////////////////////////////
    // Bus and sample drivers
    //////////////////////////////////////////////////
    task automatic busAccess(input logic we, input logic [12:0] adr, input logic [31:0] data,
                             input logic [3:0] sel, output logic [31:0] rdata);
        int waited;
        wbCyc   = 1'b1;
        wbStb   = 1'b1;
        wbWe    = we;
        wbAdr   = adr;
        wbSel   = sel;
        wbDatWr = data;
        waited  = 0;
        do begin
            @(posedge busClk);
            #1;
            waited++;
        end while (!wbAck && waited < ackTimeout);
        if (!wbAck) begin
            $display("No wbAck within %0d clocks at address 0x%h", ackTimeout, adr);
            failCount++;
        end
        rdata    = wbDatRd;
        ackCycle = cycleCount;
        @(posedge busClk);  // The master sees the acknowledge at this edge.
        #1;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe  = 1'b0;
        checkBit("wbAck", wbAck, 1'b0);
    endtask

    task automatic writeReg(input logic [12:0] adr, input logic [31:0] data, input logic [3:0] sel);
        logic [31:0] unused;
        busAccess(1'b1, adr, data, sel, unused);
        if (fieldMask(adr) != 32'h0) begin
            image[adr[3:2]] = laneMerge(image[adr[3:2]], data, sel, fieldMask(adr));
        end
    endtask

    task automatic readReg(input logic [12:0] adr, output logic [31:0] data);
        busAccess(1'b0, adr, 32'h0, 4'hF, data);
    endtask

    task automatic driveSample(input logic signed [7:0] i, input logic signed [7:0] q);
        sampleValid = 1'b1;
        sampleI     = i;
        sampleQ     = q;
        wantI.push_back(refLlr(i, image[1][15:0], image[1][18:16]));
        wantQ.push_back(refLlr(q, image[1][15:0], image[1][18:16]));
        dueCycle.push_back(cycleCount + 2);
        @(posedge busClk);
        #1;
        sampleValid = 1'b0;
    endtask

    task automatic sendData(input int count);
        for (int k = 0; k < count; k++) begin
            driveSample(8'(randBits(8)), 8'(randBits(8)));
        end
    endtask

    // Negative samples carry a hard 1.
    task automatic sendMarker(input int r, input logic corrupt);
        logic bitI;
        logic bitQ;
        logic t;
        for (int s = 0; s < ldpcPkg::markerSymbols; s++) begin
            bitI = ldpcPkg::syncMarker[2 * (ldpcPkg::markerSymbols - 1 - s) + 1];
            bitQ = ldpcPkg::syncMarker[2 * (ldpcPkg::markerSymbols - 1 - s)];
            for (int n = 0; n < r; n++) begin
                t    = bitI;
                bitI = bitQ;
                bitQ = ~t;
            end
            if (corrupt) begin
                bitI = 1'(randBits(1));
                bitQ = 1'(randBits(1));
            end
            driveSample({bitI, 7'(randBits(7))}, {bitQ, 7'(randBits(7))});
        end
    endtask

    task automatic checkSync(input ldpcPkg::syncState st, input logic sync, input logic [1:0] rot);
        logic [31:0] word;
        readReg(ldpcPkg::statusReg, word);
        checkState("status.state", ldpcPkg::syncState'(word[1:0]), st);
        checkBit("status.inSync", word[31], sync);
        checkBit("inSync", inSync, sync);
        if (sync) begin
            checkRotation("status.rotation", word[9:8], rot);
        end
    endtask

    task automatic drainLlr();
        int waited;
        waited = 0;
        while (wantI.size() != 0 && waited < 10) begin
            @(posedge busClk);
            #1;
            waited++;
        end
        if (wantI.size() != 0) begin
            $display("%0d LLR outputs never appeared", wantI.size());
            failCount++;
        end
    endtask

    task automatic checkPacing(input logic [15:0] div);
        int waited;
        writeReg(ldpcPkg::ctrlReg, 32'h0, 4'hF);
        writeReg(ldpcPkg::outputClkDivReg, {16'h0, div}, 4'h3);
        pulseCycles.delete();
        writeReg(ldpcPkg::ctrlReg, 32'h8000_0000, 4'h8);
        waited = 0;
        while (pulseCycles.size() < 4 && waited < 200) begin
            @(posedge busClk);
            #1;
            waited++;
        end
        if (pulseCycles.size() < 4) begin
            $display("Too few outputEn pulses with divider %0d", div);
            failCount++;
        end else begin
            checkInterval("first outputEn", pulseCycles[0] - ackCycle, refPulseInterval(div));
            for (int k = 1; k < 4; k++) begin
                checkInterval("outputEn spacing", pulseCycles[k] - pulseCycles[k-1],
                              refPulseInterval(div));
            end
        end
        writeReg(ldpcPkg::ctrlReg, 32'h0, 4'h8);
        pulseCycles.delete();
        repeat (40) @(posedge busClk);
        #1;
        if (pulseCycles.size() != 0) begin
            $display("outputEn kept pulsing after ldpcRun was cleared");
            failCount++;
        end
    endtask

    //////////////////////////////////////////////////
    // Output monitors
    //////////////////////////////////////////////////
    always @(negedge busClk) begin
        if (llrValid) begin
            if (wantI.size() == 0) begin
                $display("llrValid was high with no sample outstanding");
                failCount++;
            end else begin
                if (dueCycle.pop_front() != cycleCount) begin
                    $display("LLR output did not come two clocks after its sample");
                    failCount++;
                end
                checkLlr("llrI", llrI, wantI.pop_front());
                checkLlr("llrQ", llrQ, wantQ.pop_front());
            end
        end
    end

    always @(negedge busClk) begin
        if (outputEn) begin
            pulseCycles.push_back(cycleCount);
        end
    end

    initial begin
        logic [31:0] word;
        logic [31:0] data;
        logic [12:0] adr;
        arstN       = 1'b0;
        wbCyc       = 1'b0;
        wbStb       = 1'b0;
        wbWe        = 1'b0;
        wbAdr       = '0;
        wbSel       = '0;
        wbDatWr     = '0;
        sampleValid = 1'b0;
        sampleI     = '0;
        sampleQ     = '0;
        for (int k = 0; k < 3; k++) begin
            image[k] = '0;
        end
        repeat (4) @(posedge busClk);
        #1;
        arstN = 1'b1;

        // Everything reads zero out of reset and the pacer stays quiet.
        for (int k = 0; k < 3; k++) begin
            readReg(13'(4 * k), word);
            checkWord("wbDatRd", word, 32'h0);
        end
        readReg(ldpcPkg::statusReg, word);
        checkWord("statusReg", word, refStatus(1'b0, ldpcPkg::search, 2'd0));
        repeat (50) begin
            @(posedge busClk);
            #1;
            checkBit("outputEn", outputEn, 1'b0);
        end

        for (int n = 0; n < 24; n++) begin
            adr = 13'(4 * (n % 3));
            writeReg(adr, randBits(32), 4'(randBits(4)));
            readReg(adr, word);
            checkWord("wbDatRd", word, refReadback(adr));
        end
        writeReg(13'h010, randBits(32), 4'hF);  // Unmapped, so nothing changes.
        readReg(13'h010, word);
        checkWord("wbDatRd", word, 32'h0);
        readReg(13'h1FFC, word);
        checkWord("wbDatRd", word, 32'h0);
        for (int k = 0; k < 3; k++) begin
            readReg(13'(4 * k), word);
            checkWord("wbDatRd", word, refReadback(13'(4 * k)));
            writeReg(13'(4 * k), 32'h0, 4'hF);
        end

        //////////////////////////////////////////////////
        // LLR scaling, sync and pacing
        //////////////////////////////////////////////////
        for (int n = 0; n < 5; n++) begin
            data = {13'h0, 3'(randBits(3)), 16'(randBits(16)) >> (4 * n)};
            if (n == 4) begin
                data = 32'h0007_FFFF;
            end
            writeReg(ldpcPkg::inverseMeanReg, data, 4'h7);
            driveSample(-8'sd128, 8'sd127);
            driveSample(8'sd127, -8'sd128);
            sendData(30);
        end
        drainLlr();

        // 1024 bits, rate 4/5, threshold 60.
        for (int r = 0; r < 4; r++) begin
            writeReg(ldpcPkg::ctrlReg, 32'h0, 4'h8);
            writeReg(ldpcPkg::ctrlReg, 32'h803C_0002, 4'hF);
            sendMarker(r, 1'b0);
            sendData(dataLen);
            sendMarker(r, 1'b0);
            checkSync(ldpcPkg::locked, 1'b1, 2'(r));
        end
        sendData(dataLen);
        sendMarker(3, 1'b1);
        checkSync(ldpcPkg::flywheel, 1'b1, 2'd3);
        sendData(dataLen);
        sendMarker(3, 1'b1);
        checkSync(ldpcPkg::search, 1'b0, 2'd3);
        drainLlr();

        checkPacing(16'd0);
        checkPacing(16'd3);
        checkPacing(16'd17);

        $display("Checks: %0d, value errors: %0d, other failures: %0d",
                 checkCount, errorCount, failCount);
        if (errorCount == 0 && failCount == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* design/ldpcFrontEnd.sv */
`timescale 1ns/100ps

module ldpcFrontEnd (
    input  logic                                   busClk,
    input  logic                                   arstN,
    input  logic                                   wbCyc,
    input  logic                                   wbStb,
    input  logic                                   wbWe,
    input  logic [12:0]                            wbAdr,
    input  logic [3:0]                             wbSel,
    input  logic [31:0]                            wbDatWr,
    output logic [31:0]                            wbDatRd,
    output logic                                   wbAck,
    input  logic                                   sampleValid,
    input  logic signed [ldpcPkg::sampleWidth-1:0] sampleI,
    input  logic signed [ldpcPkg::sampleWidth-1:0] sampleQ,
    output logic                                   llrValid,
    output logic signed [ldpcPkg::llrWidth-1:0]    llrI,
    output logic signed [ldpcPkg::llrWidth-1:0]    llrQ,
    output logic                                   outputEn,
    output logic                                   inSync
);

    ldpcPkg::ldpcCfg   cfg;
    ldpcPkg::syncState state;
    logic [1:0]        rotation;

    ldpcRegBus regBus();

    //////////////////////////////////////////////////
    // Host side
    //////////////////////////////////////////////////
    wbSlave wbSlaveInst (
        .busClk  (busClk),
        .arstN   (arstN),
        .wbCyc   (wbCyc),
        .wbStb   (wbStb),
        .wbWe    (wbWe),
        .wbAdr   (wbAdr),
        .wbSel   (wbSel),
        .wbDatWr (wbDatWr),
        .wbDatRd (wbDatRd),
        .wbAck   (wbAck),
        .bus     (regBus.host)
    );

    ldpcRegs ldpcRegsInst (
        .busClk   (busClk),
        .arstN    (arstN),
        .bus      (regBus.regs),
        .inSync   (inSync),
        .state    (state),
        .rotation (rotation),
        .cfg      (cfg)
    );

    //////////////////////////////////////////////////
    // Sample path
    //////////////////////////////////////////////////
    // Hard decisions are the sample sign bits.
    frameSync frameSyncInst (
        .busClk      (busClk),
        .arstN       (arstN),
        .sampleValid (sampleValid),
        .signI       (sampleI[ldpcPkg::sampleWidth-1]),
        .signQ       (sampleQ[ldpcPkg::sampleWidth-1]),
        .cfg         (cfg),
        .inSync      (inSync),
        .state       (state),
        .rotation    (rotation)
    );

    llrScaler llrScalerInst (
        .busClk      (busClk),
        .arstN       (arstN),
        .sampleValid (sampleValid),
        .sampleI     (sampleI),
        .sampleQ     (sampleQ),
        .cfg         (cfg),
        .llrValid    (llrValid),
        .llrI        (llrI),
        .llrQ        (llrQ)
    );

    outputPacer outputPacerInst (
        .busClk   (busClk),
        .arstN    (arstN),
        .cfg      (cfg),
        .outputEn (outputEn)
    );

endmodule

/* design/outputPacer.sv */
`timescale 1ns/100ps

module outputPacer (
    input  logic            busClk,
    input  logic            arstN,
    input  ldpcPkg::ldpcCfg cfg,
    output logic            outputEn
);

    logic [ldpcPkg::clkDivWidth-1:0] count;

    // Held at the divider while stopped so the first pulse lands div+1 clocks after start.
    always_ff @(posedge busClk or negedge arstN) begin
        if (!arstN) begin
            count    <= '0;
            outputEn <= 1'b0;
        end else if (!cfg.ldpcRun) begin
            count    <= cfg.outputEnClkDiv;
            outputEn <= 1'b0;
        end else if (count == '0) begin
            count    <= cfg.outputEnClkDiv;
            outputEn <= 1'b1;
        end else begin
            count    <= count - 1'b1;
            outputEn <= 1'b0;
        end
    end

endmodule

/* design/llrScaler.sv */
`timescale 1ns/100ps

module llrScaler (
    input  logic                                  busClk,
    input  logic                                  arstN,
    input  logic                                  sampleValid,
    input  logic signed [ldpcPkg::sampleWidth-1:0] sampleI,
    input  logic signed [ldpcPkg::sampleWidth-1:0] sampleQ,
    input  ldpcPkg::ldpcCfg                       cfg,
    output logic                                  llrValid,
    output logic signed [ldpcPkg::llrWidth-1:0]    llrI,
    output logic signed [ldpcPkg::llrWidth-1:0]    llrQ
);

    logic                                     validS1;
    logic signed [ldpcPkg::productWidth-1:0]  prodI;
    logic signed [ldpcPkg::productWidth-1:0]  prodQ;
    logic [3:0]                               shiftS1;

    // Clamp the shifted product to the LLR range.
    function automatic logic signed [ldpcPkg::llrWidth-1:0] saturate(
        input logic signed [ldpcPkg::productWidth-1:0] v
    );
        if (v > ldpcPkg::llrMax) begin
            return ldpcPkg::llrWidth'(ldpcPkg::llrMax);
        end else if (v < ldpcPkg::llrMin) begin
            return ldpcPkg::llrWidth'(ldpcPkg::llrMin);
        end
        return v[ldpcPkg::llrWidth-1:0];
    endfunction

    always_ff @(posedge busClk or negedge arstN) begin
        if (!arstN) begin
            validS1  <= 1'b0;
            llrValid <= 1'b0;
        end else begin
            validS1  <= sampleValid;
            llrValid <= validS1;
        end
    end

    //////////////////////////////////////////////////
    // Stage 1 multiplies, stage 2 shifts and clamps
    //////////////////////////////////////////////////
    always_ff @(posedge busClk) begin
        prodI   <= sampleI * $signed({1'b0, cfg.inverseMeanMantissa});
        prodQ   <= sampleQ * $signed({1'b0, cfg.inverseMeanMantissa});
        shiftS1 <= 4'd15 - {1'b0, cfg.inverseMeanExponent};  // Mantissa is Q1.15.
        llrI    <= saturate(prodI >>> shiftS1);
        llrQ    <= saturate(prodQ >>> shiftS1);
    end

endmodule

/* design/frameSync.sv */
`timescale 1ns/100ps

module frameSync (
    input  logic                busClk,
    input  logic                arstN,
    input  logic                sampleValid,
    input  logic                signI,
    input  logic                signQ,
    input  ldpcPkg::ldpcCfg     cfg,
    output logic                inSync,
    output ldpcPkg::syncState   state,
    output logic [1:0]          rotation
);

    logic [ldpcPkg::markerBits-1:0]    history;
    logic [ldpcPkg::markerBits-1:0]    nextHistory;
    logic [ldpcPkg::countWidth-1:0]    agree [4];
    logic [3:0]                        hit;
    logic [1:0]                        firstHit;
    logic                              hitLatched;
    logic [ldpcPkg::frameCntWidth-1:0] frameCnt;
    logic [ldpcPkg::frameCntWidth-1:0] frameReload;

    // Marker as seen after r quarter turns, each mapping (I,Q) to (Q, not I).
    function automatic logic [ldpcPkg::markerBits-1:0] rotateMarker(input logic [1:0] r);
        logic [ldpcPkg::markerBits-1:0] m;
        logic                           bitI;
        m = ldpcPkg::syncMarker;
        for (int n = 0; n < 3; n++) begin
            if (n < int'(r)) begin
                for (int s = 0; s < ldpcPkg::markerSymbols; s++) begin
                    bitI       = m[2*s+1];
                    m[2*s+1]   = m[2*s];
                    m[2*s]     = ~bitI;
                end
            end
        end
        return m;
    endfunction

    function automatic logic [ldpcPkg::countWidth-1:0] countAgree(
        input logic [ldpcPkg::markerBits-1:0] a,
        input logic [ldpcPkg::markerBits-1:0] b
    );
        logic [ldpcPkg::countWidth-1:0] total;
        total = '0;
        for (int k = 0; k < ldpcPkg::markerBits; k++) begin
            total = total + ldpcPkg::countWidth'(a[k] ~^ b[k]);
        end
        return total;
    endfunction

    //////////////////////////////////////////////////
    // Correlator over the four rotations
    //////////////////////////////////////////////////
    always_comb begin
        nextHistory = {history[ldpcPkg::markerBits-3:0], signI, signQ};
        for (int r = 0; r < 4; r++) begin
            agree[r] = countAgree(nextHistory, rotateMarker(2'(r)));
            hit[r]   = ldpcPkg::thresholdWidth'(agree[r]) >= cfg.syncThreshold;
        end
        if (hit[0])      firstHit = 2'd0;
        else if (hit[1]) firstHit = 2'd1;
        else if (hit[2]) firstHit = 2'd2;
        else             firstHit = 2'd3;
    end

    assign hitLatched  = hit[rotation];
    assign frameReload = ldpcPkg::frameSymbols(cfg.codeLength4096, cfg.rate) - 1'b1;
    assign inSync      = (state == ldpcPkg::locked) || (state == ldpcPkg::flywheel);

    //////////////////////////////////////////////////
    // Sync state machine
    //////////////////////////////////////////////////
    always_ff @(posedge busClk or negedge arstN) begin
        if (!arstN) begin
            history  <= '0;
            state    <= ldpcPkg::search;
            rotation <= 2'd0;
            frameCnt <= '0;
        end else begin
            if (sampleValid) begin
                history <= nextHistory;
            end
            if (!cfg.ldpcRun) begin
                state <= ldpcPkg::search;
            end else if (sampleValid) begin
                if (state == ldpcPkg::search) begin
                    if (|hit) begin
                        state    <= ldpcPkg::check;
                        rotation <= firstHit;
                        frameCnt <= frameReload;
                    end
                end else if (frameCnt == '0) begin
                    frameCnt <= frameReload;  // Next marker is one frame later.
                    if (hitLatched) begin
                        state <= ldpcPkg::locked;
                    end else if (state == ldpcPkg::locked) begin
                        state <= ldpcPkg::flywheel;
                    end else begin
                        state <= ldpcPkg::search;
                    end
                end else begin
                    frameCnt <= frameCnt - 1'b1;
                end
            end
        end
    end

    // Rotation is latched in search only, so lock never sees it move.
    rotationHeldInSync: assert property (
        @(posedge busClk) disable iff (!arstN)
        inSync |=> $stable(rotation)
    );

endmodule

/* design/ldpcRegs.sv */
`timescale 1ns/100ps

module ldpcRegs (
    input  logic                busClk,
    input  logic                arstN,
    ldpcRegBus.regs             bus,
    input  logic                inSync,
    input  ldpcPkg::syncState   state,
    input  logic [1:0]          rotation,
    output ldpcPkg::ldpcCfg     cfg
);

    //////////////////////////////////////////////////
    // Byte-lane writes
    //////////////////////////////////////////////////
    always_ff @(posedge busClk or negedge arstN) begin
        if (!arstN) begin
            cfg <= '0;
        end else if (bus.cs) begin
            case (bus.addr)
                ldpcPkg::ctrlReg: begin
                    if (bus.wr[0]) begin
                        cfg.rate           <= ldpcPkg::codeRate'(bus.dataIn[1:0]);
                        cfg.codeLength4096 <= bus.dataIn[3];
                    end
                    if (bus.wr[2]) begin
                        cfg.syncThreshold[7:0] <= bus.dataIn[23:16];
                    end
                    if (bus.wr[3]) begin
                        cfg.syncThreshold[10:8] <= bus.dataIn[26:24];
                        cfg.ldpcRun             <= bus.dataIn[31];
                    end
                end
                ldpcPkg::inverseMeanReg: begin
                    if (bus.wr[0]) begin
                        cfg.inverseMeanMantissa[7:0] <= bus.dataIn[7:0];
                    end
                    if (bus.wr[1]) begin
                        cfg.inverseMeanMantissa[15:8] <= bus.dataIn[15:8];
                    end
                    if (bus.wr[2]) begin
                        cfg.inverseMeanExponent <= bus.dataIn[18:16];
                    end
                end
                ldpcPkg::outputClkDivReg: begin
                    if (bus.wr[0]) begin
                        cfg.outputEnClkDiv[7:0] <= bus.dataIn[7:0];
                    end
                    if (bus.wr[1]) begin
                        cfg.outputEnClkDiv[15:8] <= bus.dataIn[15:8];
                    end
                end
                default: begin
                    // Status is read-only and the rest of the map is empty.
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Read multiplexer
    //////////////////////////////////////////////////
    always_comb begin
        case (bus.addr)
            ldpcPkg::ctrlReg: begin
                bus.dataOut = {cfg.ldpcRun, 4'b0, cfg.syncThreshold, 12'b0,
                               cfg.codeLength4096, 1'b0, cfg.rate};
            end
            ldpcPkg::inverseMeanReg: begin
                bus.dataOut = {13'h0, cfg.inverseMeanExponent, cfg.inverseMeanMantissa};
            end
            ldpcPkg::outputClkDivReg: begin
                bus.dataOut = {16'h0, cfg.outputEnClkDiv};
            end
            ldpcPkg::statusReg: begin
                bus.dataOut = {inSync, 15'h0, 6'h0, rotation, 6'h0, state};
            end
            default: begin
                bus.dataOut = 32'h0;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////
    // Configuration only moves on a bus write with at least one byte lane enabled.
    cfgHeldWithoutCs: assert property (
        @(posedge busClk) disable iff (!arstN)
        !(bus.cs && (|bus.wr)) |=> $stable(cfg)
    );

endmodule

/* design/wbSlave.sv */
`timescale 1ns/100ps

module wbSlave (
    input  logic            busClk,
    input  logic            arstN,
    input  logic            wbCyc,
    input  logic            wbStb,
    input  logic            wbWe,
    input  logic [12:0]     wbAdr,
    input  logic [3:0]      wbSel,
    input  logic [31:0]     wbDatWr,
    output logic [31:0]     wbDatRd,
    output logic            wbAck,
    ldpcRegBus.host         bus
);

    logic request;

    // A new cycle is seen only while the previous one is not being acknowledged.
    assign request = wbCyc && wbStb && !wbAck;

    assign bus.cs     = request;
    assign bus.wr     = wbWe ? wbSel : 4'b0000;
    assign bus.addr   = ldpcPkg::regAddr'(wbAdr);
    assign bus.dataIn = wbDatWr;

    always_ff @(posedge busClk or negedge arstN) begin
        if (!arstN) begin
            wbAck <= 1'b0;
        end else begin
            wbAck <= request;
        end
    end

    // Read data is taken at the same edge that raises the acknowledge.
    always_ff @(posedge busClk) begin
        if (request && !wbWe) begin
            wbDatRd <= bus.dataOut;
        end
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////
    ackNeedsCycle: assert property (
        @(posedge busClk) disable iff (!arstN)
        wbAck |-> (wbCyc && wbStb)
    );

endmodule

/* design/ldpcRegBus.sv */
`timescale 1ns/100ps

// Single-cycle register access between the bus slave and the register block.
interface ldpcRegBus;

    logic               cs;
    logic [3:0]         wr;      // One enable per byte lane.
    ldpcPkg::regAddr    addr;
    logic [31:0]        dataIn;
    logic [31:0]        dataOut;

    modport host (
        output cs,
        output wr,
        output addr,
        output dataIn,
        input  dataOut
    );

    modport regs (
        input  cs,
        input  wr,
        input  addr,
        input  dataIn,
        output dataOut
    );

endinterface

/* design/ldpcPkg.sv */
package ldpcPkg;

    //////////////////////////////////////////////////
    // Widths and constants
    //////////////////////////////////////////////////
    localparam int sampleWidth    = 8;
    localparam int llrWidth       = 6;
    localparam int mantissaWidth  = 16;
    localparam int productWidth   = sampleWidth + mantissaWidth + 1;
    localparam int llrMax         = 2 ** (llrWidth - 1) - 1;
    localparam int llrMin         = -(2 ** (llrWidth - 1));
    localparam int thresholdWidth = 11;
    localparam int clkDivWidth    = 16;
    localparam int frameCntWidth  = 13;  // Longest frame is 4128 symbols.

    localparam int markerSymbols  = 32;
    localparam int markerBits     = 2 * markerSymbols;
    localparam int countWidth     = $clog2(markerBits + 1);

    // First symbol sits in the top two bits, I bit above Q bit.
    localparam logic [markerBits-1:0] syncMarker = 64'h1ACF_FC1D_3B8E_64A5;

    //////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////
    typedef enum logic [12:0] {
        ctrlReg         = 13'h000,
        inverseMeanReg  = 13'h004,
        outputClkDivReg = 13'h008,
        statusReg       = 13'h00C
    } regAddr;

    typedef enum logic [1:0] {search, check, locked, flywheel} syncState;

    // Code 3 is reserved and decodes like rate1_2.
    typedef enum logic [1:0] {rate1_2 = 2'd0, rate2_3 = 2'd1, rate4_5 = 2'd2} codeRate;

    typedef struct packed {
        logic                      codeLength4096;
        codeRate                   rate;
        logic [thresholdWidth-1:0] syncThreshold;
        logic                      ldpcRun;
        logic [mantissaWidth-1:0]  inverseMeanMantissa;
        logic [2:0]                inverseMeanExponent;
        logic [clkDivWidth-1:0]    outputEnClkDiv;
    } ldpcCfg;

    // Symbols per frame: codeword bits plus the 64 marker bits, two bits a symbol.
    function automatic logic [frameCntWidth-1:0] frameSymbols(input logic lengthSel,
                                                              input codeRate rate);
        int infoBits;
        int codeBits;
        infoBits = lengthSel ? 4096 : 1024;
        case (rate)
            rate2_3: codeBits = infoBits * 3 / 2;
            rate4_5: codeBits = infoBits * 5 / 4;
            default: codeBits = infoBits * 2;
        endcase
        return frameCntWidth'((codeBits + markerBits) / 2);
    endfunction

endpackage
